// ==== source/cipher_ctrl_macros.svh ====
`ifndef CIPHER_CTRL_MACROS_SVH
`define CIPHER_CTRL_MACROS_SVH

////////////////////////////////////////////////////////////
// Encoding widths
////////////////////////////////////////////////////////////

`define CIPHER_SP2V_W    3                // Bits per sparse two-value code
`define CIPHER_NUM_RAILS `CIPHER_SP2V_W   // One rail per code bit

////////////////////////////////////////////////////////////
// Round sequencing
////////////////////////////////////////////////////////////

`define CIPHER_RND_W  4
`define CIPHER_NR_128 10   // 128-bit key
`define CIPHER_NR_192 12
`define CIPHER_NR_256 14

`endif

// ==== source/sp2v_pkg.sv ====
`default_nettype none
`include "cipher_ctrl_macros.svh"

package sp2v_pkg;

  ////////////////////////////////////////////////////////////
  // Sparse two-value code
  ////////////////////////////////////////////////////////////

  // Only these two values are legal
  // Bits 0 and 1 are active high, bit 2 is active low
  typedef enum logic [`CIPHER_SP2V_W-1:0] {
    SP2V_HIGH = 3'b011,
    SP2V_LOW  = 3'b100
  } sp2v_e;

  // One bit of a code per rail
  typedef logic [`CIPHER_NUM_RAILS-1:0] sp2v_rails_t;

endpackage

`default_nettype wire

// ==== source/cipher_ctrl_pkg.sv ====
`default_nettype none
`include "cipher_ctrl_macros.svh"

package cipher_ctrl_pkg;

  ////////////////////////////////////////////////////////////
  // Configuration
  ////////////////////////////////////////////////////////////

  typedef enum logic {
    CIPH_FWD = 1'b0,
    CIPH_INV = 1'b1
  } ciph_op_e;

  typedef enum logic [2:0] {   // One-hot
    AES_128 = 3'b001,
    AES_192 = 3'b010,
    AES_256 = 3'b100
  } key_len_e;

  typedef logic [`CIPHER_RND_W-1:0] rnd_ctr_t;

  // Sparse state codes, any two differ in at least two bits
  typedef enum logic [4:0] {
    IDLE   = 5'b00011,
    INIT   = 5'b01100,
    ROUND  = 5'b10101,
    FINISH = 5'b11010,
    ERROR  = 5'b10110
  } ctrl_state_e;

  ////////////////////////////////////////////////////////////
  // Datapath selectors
  ////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    STATE_INIT  = 2'b01,
    STATE_ROUND = 2'b10
  } state_sel_e;

  typedef enum logic [2:0] {
    ADD_RK_INIT  = 3'b001,
    ADD_RK_ROUND = 3'b010,
    ADD_RK_FINAL = 3'b100
  } add_rk_sel_e;

  ////////////////////////////////////////////////////////////
  // Bundles
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    ciph_op_e op;
    key_len_e key_len;
  } cfg_t;

  typedef struct packed {
    state_sel_e  state_sel;
    add_rk_sel_e add_rk_sel;
  } sel_t;

  typedef struct packed {
    sp2v_pkg::sp2v_e in_valid;
    sp2v_pkg::sp2v_e out_ready;
    sp2v_pkg::sp2v_e sub_bytes_out_req;
    sp2v_pkg::sp2v_e key_expand_out_req;
  } sp_in_t;

  // One bit of each sparse input, as seen by a single rail
  typedef struct packed {
    logic in_valid;
    logic out_ready;
    logic sub_bytes_out_req;
    logic key_expand_out_req;
  } rail_in_t;

  typedef struct packed {
    logic     in_ready;
    logic     out_valid;
    logic     state_we;
    logic     sub_bytes_en;
    logic     sub_bytes_out_ack;
    logic     key_expand_en;
    logic     key_expand_out_ack;
    logic     alert;
    sel_t     sel;
    rnd_ctr_t rnd;
    ciph_op_e op;     // Latched at acceptance
    logic     busy;
  } rail_out_t;

endpackage

`default_nettype wire

// ==== source/sparse_in_chk.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cipher_ctrl_macros.svh"

module sparse_in_chk (
  input  wire cipher_ctrl_pkg::sp_in_t                            sp_i,
  output cipher_ctrl_pkg::rail_in_t [`CIPHER_NUM_RAILS-1:0] rails_o,
  output logic                                                    enc_err_o
);

  import sp2v_pkg::*;
  import cipher_ctrl_pkg::*;

  localparam int num_sig = 4;

  logic [num_sig-1:0][`CIPHER_SP2V_W-1:0] codes;
  logic [num_sig-1:0]                     code_err;

  assign codes = sp_i;  // Index 3 is in_valid

  // Every code must be one of the two legal values
  always_comb begin
    for (int k = 0; k < num_sig; k++) begin
      code_err[k] = !(codes[k] inside {SP2V_HIGH, SP2V_LOW});
    end
  end

  assign enc_err_o = |code_err;

  // Rail i sees bit i of every code
  always_comb begin
    for (int i = 0; i < `CIPHER_NUM_RAILS; i++) begin
      rails_o[i].in_valid           = sp_i.in_valid[i];
      rails_o[i].out_ready          = sp_i.out_ready[i];
      rails_o[i].sub_bytes_out_req  = sp_i.sub_bytes_out_req[i];
      rails_o[i].key_expand_out_req = sp_i.key_expand_out_req[i];
    end
  end

  // Unknown bits would slip past the legal-value compare
  always_comb begin
    assert final (!$isunknown(sp_i))
      else $error("sparse_in_chk: unknown bits on a sparse input");
  end

endmodule

`default_nettype wire

// ==== source/round_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cipher_ctrl_macros.svh"

module round_fsm #(
  parameter bit inv_rail = 1'b0   // Rail on code bit 2, handshakes active low
) (
  input  wire logic                       clk_i,
  input  wire logic                       rst_ni,
  input  wire cipher_ctrl_pkg::rail_in_t  rail_i,
  input  wire logic                       cfg_valid_i,
  input  wire cipher_ctrl_pkg::cfg_t      cfg_i,
  input  wire logic                       enc_err_i,
  input  wire logic                       mr_err_i,
  output cipher_ctrl_pkg::rail_out_t      rail_o
);

  import cipher_ctrl_pkg::*;

  ctrl_state_e state_d, state_q;
  rnd_ctr_t    rnd_d, rnd_q;
  rnd_ctr_t    nr_d, nr_q;      // Round total of the current block
  ciph_op_e    op_d, op_q;
  rail_in_t    rail_in;         // Inputs in active-high form
  rail_out_t   out_act;         // Outputs before polarity
  logic        reqs_done;
  logic        last_rnd;

  assign rail_in   = inv_rail ? rail_in_t'(~rail_i) : rail_i;
  assign reqs_done = rail_in.sub_bytes_out_req & rail_in.key_expand_out_req;
  assign last_rnd  = (rnd_q == nr_q);

  ////////////////////////////////////////////////////////////
  // Next state and outputs
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    rnd_d   = rnd_q;
    nr_d    = nr_q;
    op_d    = op_q;

    out_act                = '0;
    out_act.sel.state_sel  = STATE_ROUND;  // Idle selector value
    out_act.sel.add_rk_sel = ADD_RK_ROUND;
    out_act.rnd            = rnd_q;
    out_act.op             = op_q;

    case (state_q)
      IDLE: begin
        out_act.in_ready = 1'b1;
        if (rail_in.in_valid) begin
          op_d    = cfg_i.op;
          state_d = INIT;
          case (cfg_i.key_len)
            AES_128: nr_d = rnd_ctr_t'(`CIPHER_NR_128);
            AES_192: nr_d = rnd_ctr_t'(`CIPHER_NR_192);
            AES_256: nr_d = rnd_ctr_t'(`CIPHER_NR_256);
            default: state_d = ERROR;  // Key length not one-hot
          endcase
          if (!cfg_valid_i) begin
            state_d = ERROR;
          end
        end
      end

      INIT: begin
        // Initial key addition, round 0
        out_act.busy           = 1'b1;
        out_act.state_we       = 1'b1;
        out_act.sel.state_sel  = STATE_INIT;
        out_act.sel.add_rk_sel = ADD_RK_INIT;
        rnd_d                  = rnd_ctr_t'(1);
        state_d                = ROUND;
      end

      ROUND: begin
        out_act.busy          = 1'b1;
        out_act.sub_bytes_en  = 1'b1;
        out_act.key_expand_en = 1'b1;
        if (last_rnd) begin
          out_act.sel.add_rk_sel = ADD_RK_FINAL;
        end
        // Wait for both datapaths
        if (reqs_done) begin
          out_act.sub_bytes_out_ack  = 1'b1;
          out_act.key_expand_out_ack = 1'b1;
          out_act.state_we           = 1'b1;
          if (last_rnd) begin
            rnd_d   = '0;
            state_d = FINISH;
          end else begin
            rnd_d = rnd_q + rnd_ctr_t'(1);
          end
        end
      end

      FINISH: begin
        out_act.busy      = 1'b1;
        out_act.out_valid = 1'b1;
        if (rail_in.out_ready) begin
          state_d = IDLE;
        end
      end

      ERROR: begin
        out_act.alert = 1'b1;  // Terminal until reset
      end

      default: begin
        out_act.alert = 1'b1;
        state_d       = ERROR;
      end
    endcase

    // Checker results only steer the next state
    if (enc_err_i || mr_err_i) begin
      state_d = ERROR;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      rnd_q   <= '0;
      nr_q    <= '0;
      op_q    <= CIPH_FWD;
    end else begin
      state_q <= state_d;
      rnd_q   <= rnd_d;
      nr_q    <= nr_d;
      op_q    <= op_d;
    end
  end

  ////////////////////////////////////////////////////////////
  // Output polarity
  ////////////////////////////////////////////////////////////

  always_comb begin
    rail_o = out_act;
    if (inv_rail) begin
      rail_o.in_ready           = ~out_act.in_ready;
      rail_o.out_valid          = ~out_act.out_valid;
      rail_o.state_we           = ~out_act.state_we;
      rail_o.sub_bytes_en       = ~out_act.sub_bytes_en;
      rail_o.sub_bytes_out_ack  = ~out_act.sub_bytes_out_ack;
      rail_o.key_expand_en      = ~out_act.key_expand_en;
      rail_o.key_expand_out_ack = ~out_act.key_expand_out_ack;
    end
  end

  // Acks at the rail pins only when both reqs are at the pins in this cycle
  ack_needs_reqs: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ((rail_o.sub_bytes_out_ack ^ inv_rail) || (rail_o.key_expand_out_ack ^ inv_rail)) |->
    ((rail_i.sub_bytes_out_req ^ inv_rail) && (rail_i.key_expand_out_req ^ inv_rail)));

  // No way out of ERROR except reset
  error_terminal: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_q == ERROR) |=> (state_q == ERROR));

endmodule

`default_nettype wire

// ==== source/rail_combine.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cipher_ctrl_macros.svh"

module rail_combine (
  input  wire cipher_ctrl_pkg::rail_out_t [`CIPHER_NUM_RAILS-1:0] rails_i,
  output sp2v_pkg::sp2v_e                in_ready_o,
  output sp2v_pkg::sp2v_e                out_valid_o,
  output sp2v_pkg::sp2v_e                state_we_o,
  output sp2v_pkg::sp2v_e                sub_bytes_en_o,
  output sp2v_pkg::sp2v_e                sub_bytes_out_ack_o,
  output sp2v_pkg::sp2v_e                key_expand_en_o,
  output sp2v_pkg::sp2v_e                key_expand_out_ack_o,
  output cipher_ctrl_pkg::sel_t          sel_o,
  output cipher_ctrl_pkg::rnd_ctr_t      round_o,
  output cipher_ctrl_pkg::ciph_op_e      key_expand_op_o,
  output logic                           alert_o,
  output logic                           mr_err_o
);

  import sp2v_pkg::*;
  import cipher_ctrl_pkg::*;

  sp2v_rails_t in_ready, out_valid, state_we, sub_bytes_en, sub_bytes_ack;
  sp2v_rails_t key_expand_en, key_expand_ack, alert, busy;

  logic [$bits(sel_t)-1:0] sel_or;
  rnd_ctr_t                rnd_or;
  logic                    op_or;

  // Gather code bits, OR the shared fields
  always_comb begin
    sel_or = '0;
    rnd_or = '0;
    op_or  = 1'b0;
    for (int i = 0; i < `CIPHER_NUM_RAILS; i++) begin
      in_ready[i]       = rails_i[i].in_ready;
      out_valid[i]      = rails_i[i].out_valid;
      state_we[i]       = rails_i[i].state_we;
      sub_bytes_en[i]   = rails_i[i].sub_bytes_en;
      sub_bytes_ack[i]  = rails_i[i].sub_bytes_out_ack;
      key_expand_en[i]  = rails_i[i].key_expand_en;
      key_expand_ack[i] = rails_i[i].key_expand_out_ack;
      alert[i]          = rails_i[i].alert;
      busy[i]           = rails_i[i].busy;
      sel_or            = sel_or | rails_i[i].sel;
      rnd_or            = rnd_or | rails_i[i].rnd;
      op_or             = op_or | rails_i[i].op;
    end
  end

  assign in_ready_o           = sp2v_e'(in_ready);
  assign out_valid_o          = sp2v_e'(out_valid);
  assign state_we_o           = sp2v_e'(state_we);
  assign sub_bytes_en_o       = sp2v_e'(sub_bytes_en);
  assign sub_bytes_out_ack_o  = sp2v_e'(sub_bytes_ack);
  assign key_expand_en_o      = sp2v_e'(key_expand_en);
  assign key_expand_out_ack_o = sp2v_e'(key_expand_ack);

  assign sel_o           = sel_t'(sel_or);
  assign round_o         = rnd_or;
  assign alert_o         = |alert;
  assign key_expand_op_o = (|busy) ? ciph_op_e'(op_or) : CIPH_FWD;

  // A rail that differs from the OR result disagrees with another rail
  always_comb begin
    mr_err_o = 1'b0;
    for (int i = 0; i < `CIPHER_NUM_RAILS; i++) begin
      if (rails_i[i].sel != sel_o || rails_i[i].rnd != rnd_or ||
          rails_i[i].op != ciph_op_e'(op_or)) begin
        mr_err_o = 1'b1;
      end
    end
  end

  always_comb begin
    assert final ($onehot(sel_o.add_rk_sel))
      else $error("rail_combine: add_rk_sel not one-hot");
  end

endmodule

`default_nettype wire

// ==== source/cipher_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cipher_ctrl_macros.svh"

module cipher_ctrl (
  input  wire logic                       clk_i,
  input  wire logic                       rst_ni,
  input  wire sp2v_pkg::sp2v_e            in_valid_i,
  input  wire sp2v_pkg::sp2v_e            out_ready_i,
  input  wire sp2v_pkg::sp2v_e            sub_bytes_out_req_i,
  input  wire sp2v_pkg::sp2v_e            key_expand_out_req_i,
  input  wire logic                       cfg_valid_i,
  input  wire cipher_ctrl_pkg::cfg_t      cfg_i,
  output sp2v_pkg::sp2v_e                 in_ready_o,
  output sp2v_pkg::sp2v_e                 out_valid_o,
  output sp2v_pkg::sp2v_e                 state_we_o,
  output sp2v_pkg::sp2v_e                 sub_bytes_en_o,
  output sp2v_pkg::sp2v_e                 sub_bytes_out_ack_o,
  output sp2v_pkg::sp2v_e                 key_expand_en_o,
  output sp2v_pkg::sp2v_e                 key_expand_out_ack_o,
  output cipher_ctrl_pkg::sel_t           sel_o,
  output cipher_ctrl_pkg::rnd_ctr_t       round_o,
  output cipher_ctrl_pkg::ciph_op_e       key_expand_op_o,
  output logic                            alert_o
);

  import sp2v_pkg::*;
  import cipher_ctrl_pkg::*;

  // A rail is inverted where the HIGH code has a zero
  localparam sp2v_rails_t high_bits = SP2V_HIGH;

  sp_in_t                               sp_in;
  rail_in_t  [`CIPHER_NUM_RAILS-1:0]    rail_in;
  rail_out_t [`CIPHER_NUM_RAILS-1:0]    rail_out;
  logic                                 enc_err;
  logic                                 mr_err;

  assign sp_in = '{
    in_valid:           in_valid_i,
    out_ready:          out_ready_i,
    sub_bytes_out_req:  sub_bytes_out_req_i,
    key_expand_out_req: key_expand_out_req_i
  };

  sparse_in_chk u_sparse_in_chk (
    .sp_i      (sp_in),
    .rails_o   (rail_in),
    .enc_err_o (enc_err)
  );

  ////////////////////////////////////////////////////////////
  // Redundant rails
  ////////////////////////////////////////////////////////////

  for (genvar i = 0; i < `CIPHER_NUM_RAILS; i++) begin : gen_rail
    round_fsm #(
      .inv_rail (!high_bits[i])
    ) u_round_fsm (
      .clk_i       (clk_i),
      .rst_ni      (rst_ni),
      .rail_i      (rail_in[i]),
      .cfg_valid_i (cfg_valid_i),
      .cfg_i       (cfg_i),
      .enc_err_i   (enc_err),
      .mr_err_i    (mr_err),
      .rail_o      (rail_out[i])
    );
  end

  rail_combine u_rail_combine (
    .rails_i              (rail_out),
    .in_ready_o           (in_ready_o),
    .out_valid_o          (out_valid_o),
    .state_we_o           (state_we_o),
    .sub_bytes_en_o       (sub_bytes_en_o),
    .sub_bytes_out_ack_o  (sub_bytes_out_ack_o),
    .key_expand_en_o      (key_expand_en_o),
    .key_expand_out_ack_o (key_expand_out_ack_o),
    .sel_o                (sel_o),
    .round_o              (round_o),
    .key_expand_op_o      (key_expand_op_o),
    .alert_o              (alert_o),
    .mr_err_o             (mr_err)
  );

endmodule

`default_nettype wire

// ==== dv/cipher_ctrl_tb.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cipher_ctrl_macros.svh"

module cipher_ctrl_tb;

  import sp2v_pkg::*;
  import cipher_ctrl_pkg::*;

  localparam int num_ops    = 20;
  localparam int op_budget  = 40;                          // Cycles per operation
  localparam int max_cycles = num_ops * op_budget + 150;   // Resets and error tests

  logic  clk_i                = 1'b0;
  logic  rst_ni               = 1'b1;
  sp2v_e in_valid_i           = SP2V_LOW;
  sp2v_e out_ready_i          = SP2V_LOW;
  sp2v_e sub_bytes_out_req_i  = SP2V_LOW;
  sp2v_e key_expand_out_req_i = SP2V_LOW;
  logic  cfg_valid_i          = 1'b0;
  cfg_t  cfg_i                = '{op: CIPH_FWD, key_len: AES_128};

  sp2v_e     in_ready_o, out_valid_o, state_we_o, sub_bytes_en_o, sub_bytes_out_ack_o;
  sp2v_e     key_expand_en_o, key_expand_out_ack_o;
  sel_t      sel_o;
  rnd_ctr_t  round_o;
  ciph_op_e  key_expand_op_o;
  logic      alert_o;

  logic [31:0] lfsr = 32'h0c64_2433;
  bit          req_stall = 1'b0;    // Random datapath stalls
  bit          out_stall = 1'b0;    // Random output back-pressure
  int          errors = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  int          cycle_count = 0;

  cipher_ctrl UUT (.*);

  initial forever #50 clk_i = ~clk_i;

  initial begin : watchdog
    while (cycle_count < max_cycles) begin
      @(posedge clk_i);
      cycle_count++;
    end
    $display("Timeout: the run did not end within %0d cycles", max_cycles);
    $display("** FAIL **");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // Expected values from the round rules
  ////////////////////////////////////////////////////////////

  function automatic int rounds_for(input key_len_e kl);
    case (kl)
      AES_128: return `CIPHER_NR_128;
      AES_192: return `CIPHER_NR_192;
      AES_256: return `CIPHER_NR_256;
      default: return 0;
    endcase
  endfunction

  function automatic sel_t exp_pulse_sel(input int n, input int nr);
    if (n == 0) return '{state_sel: STATE_INIT, add_rk_sel: ADD_RK_INIT};
    if (n == nr) return '{state_sel: STATE_ROUND, add_rk_sel: ADD_RK_FINAL};
    return '{state_sel: STATE_ROUND, add_rk_sel: ADD_RK_ROUND};
  endfunction

  function automatic logic is_legal(input sp2v_e c);
    return (c == SP2V_HIGH) || (c == SP2V_LOW);
  endfunction

  logic accept, out_take, ins_legal, outs_legal, outs_low;

  assign accept   = (in_valid_i == SP2V_HIGH) && (in_ready_o == SP2V_HIGH);
  assign out_take = (out_valid_o == SP2V_HIGH) && (out_ready_i == SP2V_HIGH);
  assign ins_legal = is_legal(in_valid_i) && is_legal(out_ready_i) &&
                     is_legal(sub_bytes_out_req_i) && is_legal(key_expand_out_req_i);
  assign outs_legal = is_legal(in_ready_o) && is_legal(out_valid_o) && is_legal(state_we_o) &&
                      is_legal(sub_bytes_en_o) && is_legal(sub_bytes_out_ack_o) &&
                      is_legal(key_expand_en_o) && is_legal(key_expand_out_ack_o);
  assign outs_low = (in_ready_o == SP2V_LOW) && (out_valid_o == SP2V_LOW) &&
                    (state_we_o == SP2V_LOW) && (sub_bytes_en_o == SP2V_LOW) &&
                    (sub_bytes_out_ack_o == SP2V_LOW) && (key_expand_en_o == SP2V_LOW) &&
                    (key_expand_out_ack_o == SP2V_LOW);

  // Port history
  logic     fresh, in_op, out_seen, last_we, pending_out, done_prev, err_prev, alert_seen;
  int       we_count, exp_nr, op_cycles;
  ciph_op_e acc_op;
  rnd_ctr_t last_round;

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fresh      <= 1'b1;
      in_op      <= 1'b0;
      out_seen   <= 1'b0;
      we_count   <= 0;
      exp_nr     <= 0;
      op_cycles  <= 0;
      acc_op     <= CIPH_FWD;
      last_we    <= 1'b0;
      last_round <= '0;
      pending_out <= 1'b0;
      done_prev  <= 1'b0;
      err_prev   <= 1'b0;
      alert_seen <= 1'b0;
    end else begin
      fresh <= 1'b0;
      if (accept) begin
        in_op     <= 1'b1;
        out_seen  <= 1'b0;
        we_count  <= 0;
        op_cycles <= 0;
        exp_nr    <= rounds_for(cfg_i.key_len);
        acc_op    <= cfg_i.op;
      end else if (in_op) begin
        op_cycles <= op_cycles + 1;
        if (state_we_o == SP2V_HIGH) we_count <= we_count + 1;
        if (out_valid_o == SP2V_HIGH) out_seen <= 1'b1;
        if (out_take) in_op <= 1'b0;
      end
      last_we     <= (state_we_o == SP2V_HIGH);
      last_round  <= round_o;
      pending_out <= (out_valid_o == SP2V_HIGH) && (out_ready_i != SP2V_HIGH);
      done_prev   <= out_take;
      err_prev    <= !ins_legal || (accept && !$onehot(cfg_i.key_len));
      if (alert_o) alert_seen <= 1'b1;
    end
  end

  task automatic report_mismatch(input string msg);
    errors++;
    $display("Mismatch at %0d ns: %s", $time, msg);
  endtask

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////

  assert property (@(posedge clk_i) disable iff (!rst_ni) fresh |->
    (in_ready_o == SP2V_HIGH && sub_bytes_out_ack_o == SP2V_LOW && !alert_o &&
     out_valid_o == SP2V_LOW && state_we_o == SP2V_LOW && sub_bytes_en_o == SP2V_LOW &&
     key_expand_en_o == SP2V_LOW && key_expand_out_ack_o == SP2V_LOW))
    else report_mismatch("outputs after reset");
  assert property (@(posedge clk_i) disable iff (!rst_ni) outs_legal)
    else report_mismatch("illegal sparse output code");
  assert property (@(posedge clk_i) disable iff (!rst_ni) (state_we_o == SP2V_HIGH) |->
    (in_op && round_o == rnd_ctr_t'(we_count) && sel_o == exp_pulse_sel(we_count, exp_nr)))
    else report_mismatch("round number or selectors on a state write");
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (out_valid_o == SP2V_HIGH) |-> (in_op && we_count == exp_nr + 1))
    else report_mismatch("state write count before output valid");
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (out_valid_o == SP2V_HIGH && !out_seen && !req_stall) |-> (op_cycles == exp_nr + 1))
    else report_mismatch("latency without stalls");
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (in_op && !alert_o) |-> (key_expand_op_o == acc_op))
    else report_mismatch("key expansion operation");
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    !in_op |-> (key_expand_op_o == CIPH_FWD))
    else report_mismatch("key expansion operation while idle");
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (sub_bytes_out_ack_o == SP2V_HIGH || key_expand_out_ack_o == SP2V_HIGH) |->
    (sub_bytes_out_req_i == SP2V_HIGH && key_expand_out_req_i == SP2V_HIGH))
    else report_mismatch("ack without both reqs");
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (sub_bytes_en_o == SP2V_HIGH && key_expand_en_o == SP2V_HIGH &&
     sub_bytes_out_req_i == SP2V_HIGH && key_expand_out_req_i == SP2V_HIGH) |->
    (sub_bytes_out_ack_o == SP2V_HIGH && key_expand_out_ack_o == SP2V_HIGH &&
     state_we_o == SP2V_HIGH))
    else report_mismatch("both reqs seen but no ack");
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (in_op && !last_we) |-> (round_o == last_round))
    else report_mismatch("round number moved without a state write");
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    pending_out |-> (out_valid_o == SP2V_HIGH))
    else report_mismatch("output valid dropped before it was taken");
  assert property (@(posedge clk_i) disable iff (!rst_ni) in_op |-> (in_ready_o == SP2V_LOW))
    else report_mismatch("input ready while busy");
  assert property (@(posedge clk_i) disable iff (!rst_ni) done_prev |->
    (in_ready_o == SP2V_HIGH))
    else report_mismatch("input ready after the output handshake");
  assert property (@(posedge clk_i) disable iff (!rst_ni) err_prev |-> alert_o)
    else report_mismatch("alert missing after an error");
  assert property (@(posedge clk_i) disable iff (!rst_ni) (!err_prev && !alert_seen) |-> !alert_o)
    else report_mismatch("alert without an error");
  assert property (@(posedge clk_i) disable iff (!rst_ni) alert_seen |-> (alert_o && outs_low))
    else report_mismatch("error state not held");

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // x^32 + x^22 + x^2 + x + 1
  endfunction

  task automatic draw_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int k = 0; k < n; k++) begin
      v    = {v[30:0], lfsr[31]};
      lfsr = lfsr_step(lfsr);
    end
  endtask

  task automatic pick_stall(output int s);
    logic [31:0] r;
    s = 0;
    if (req_stall) begin
      draw_bits(1, r);
      s = r[0] ? 1 : 0;
    end
  endtask

  task automatic random_cfg(output cfg_t c);
    logic [31:0] r;
    draw_bits(3, r);
    c.op = r[0] ? CIPH_INV : CIPH_FWD;
    case (r[2:1])
      2'd0:    c.key_len = AES_128;
      2'd1:    c.key_len = AES_192;
      default: c.key_len = AES_256;
    endcase
  endtask

  task automatic reset_dut();
    rst_ni               = 1'b0;
    in_valid_i           = SP2V_LOW;
    out_ready_i          = SP2V_LOW;
    sub_bytes_out_req_i  = SP2V_LOW;
    key_expand_out_req_i = SP2V_LOW;
    cfg_valid_i          = 1'b0;
    repeat (8) @(negedge clk_i);
    rst_ni = 1'b1;
  endtask

  // One block through the controller, playing both datapaths and the consumer
  task automatic run_op(input cfg_t c);
    logic [31:0] r;
    logic [1:0]  req;
    int          stall [2];
    logic        taking;
    logic        done;
    req    = '0;
    taking = 1'b0;
    done   = 1'b0;
    for (int k = 0; k < 2; k++) pick_stall(stall[k]);
    @(negedge clk_i);
    in_valid_i  = SP2V_HIGH;
    cfg_valid_i = 1'b1;
    cfg_i       = c;
    while (in_ready_o != SP2V_HIGH) @(negedge clk_i);
    @(negedge clk_i);          // Accepted on the edge just passed
    in_valid_i  = SP2V_LOW;
    cfg_valid_i = 1'b0;
    while (!done && !alert_o) begin
      if (sub_bytes_en_o == SP2V_HIGH && key_expand_en_o == SP2V_HIGH) begin
        for (int k = 0; k < 2; k++) begin
          if (&req) begin      // Both taken last edge
            pick_stall(stall[k]);
            req[k] = (stall[k] == 0);
          end else if (!req[k]) begin
            if (stall[k] > 0) stall[k]--;
            if (stall[k] == 0) req[k] = 1'b1;
          end
        end
      end else begin
        req = '0;
      end
      if (taking) begin
        done        = 1'b1;
        out_ready_i = SP2V_LOW;
      end else if (out_valid_o == SP2V_HIGH) begin
        draw_bits(1, r);
        taking      = !out_stall || r[0];
        out_ready_i = taking ? SP2V_HIGH : SP2V_LOW;
      end
      sub_bytes_out_req_i  = req[0] ? SP2V_HIGH : SP2V_LOW;
      key_expand_out_req_i = req[1] ? SP2V_HIGH : SP2V_LOW;
      if (!done) @(negedge clk_i);
    end
    sub_bytes_out_req_i  = SP2V_LOW;
    key_expand_out_req_i = SP2V_LOW;
    out_ready_i          = SP2V_LOW;
  endtask

  // Push every handshake while the alert holds the controller
  task automatic poke_locked(input int n);
    repeat (n) begin
      @(negedge clk_i);
      in_valid_i           = SP2V_HIGH;
      cfg_valid_i          = 1'b1;
      out_ready_i          = SP2V_HIGH;
      sub_bytes_out_req_i  = SP2V_HIGH;
      key_expand_out_req_i = SP2V_HIGH;
    end
    @(negedge clk_i);
    in_valid_i           = SP2V_LOW;
    cfg_valid_i          = 1'b0;
    out_ready_i          = SP2V_LOW;
    sub_bytes_out_req_i  = SP2V_LOW;
    key_expand_out_req_i = SP2V_LOW;
  endtask

  task automatic close_test(input string name, input int errs_before);
    repeat (2) @(negedge clk_i);
    tests_run++;
    if (errors == errs_before) begin
      $display("Test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("Test %0d %s: %0d errors", tests_run, name, errors - errs_before);
    end
  endtask

  initial begin : main
    cfg_t        c;
    logic [31:0] r;
    logic [2:0]  kl;
    int          errs_before;

    reset_dut();
    errs_before = errors;
    repeat (3) @(negedge clk_i);
    close_test("reset values", errs_before);

    errs_before = errors;
    for (int k = 0; k < 6; k++) begin    // Every key length, both operations
      c.op      = k[0] ? CIPH_INV : CIPH_FWD;
      c.key_len = (k < 2) ? AES_128 : ((k < 4) ? AES_192 : AES_256);
      run_op(c);
    end
    close_test("round sequence", errs_before);

    errs_before = errors;
    req_stall   = 1'b1;
    repeat (6) begin
      random_cfg(c);
      run_op(c);
    end
    close_test("datapath wait", errs_before);

    errs_before = errors;
    out_stall   = 1'b1;
    repeat (6) begin
      random_cfg(c);
      run_op(c);
    end
    close_test("output back-pressure", errs_before);

    errs_before = errors;
    reset_dut();
    @(negedge clk_i);
    in_valid_i = sp2v_e'(3'b000);
    @(negedge clk_i);
    in_valid_i = SP2V_LOW;
    poke_locked(6);
    close_test("invalid input code", errs_before);

    errs_before = errors;
    reset_dut();
    random_cfg(c);
    draw_bits(3, r);
    kl = r[2:0];
    if ($onehot(kl)) kl = ~kl;
    c.key_len = key_len_e'(kl);
    @(negedge clk_i);
    in_valid_i  = SP2V_HIGH;
    cfg_valid_i = 1'b1;
    cfg_i       = c;
    @(negedge clk_i);
    in_valid_i  = SP2V_LOW;
    cfg_valid_i = 1'b0;
    poke_locked(6);
    close_test("invalid key length", errs_before);

    $display("Tests %0d, failed %0d, mismatches %0d", tests_run, tests_failed, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+source
source/sp2v_pkg.sv
source/cipher_ctrl_pkg.sv
source/sparse_in_chk.sv
source/round_fsm.sv
source/rail_combine.sv
source/cipher_ctrl.sv
dv/cipher_ctrl_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build the cipher_ctrl testbench with Verilator, run it, then look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ps --top-module cipher_ctrl_tb \
  -f files.f -o cipher_ctrl_sim > build.log 2>&1 || { cat build.log; exit 1; }

./obj_dir/cipher_ctrl_sim > sim.log 2>&1
cat sim.log
grep -qx '\*\* PASS \*\*' sim.log && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
